// File: common/csr_pkg.sv
package csr_pkg;

    // ====================
    // Widths and operations
    // ====================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Operation code 0 leaves the register alone
    localparam logic [1:0] CSR_OP_WRITE = 2'd1;
    localparam logic [1:0] CSR_OP_SET   = 2'd2;
    localparam logic [1:0] CSR_OP_CLEAR = 2'd3;

    // ====================
    // CSR addresses
    // ====================
    // Machine trap setup and handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP      = 12'h344;
    // Machine counters
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH = 12'hB82;
    // Read-only user aliases
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE    = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET  = 12'hC02;
    localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [CSR_ADDR_W-1:0] CSR_INSTRETH = 12'hC82;
    // Custom timer and random number
    localparam logic [CSR_ADDR_W-1:0] CSR_CUSTOM_MTIME    = 12'hBC0;
    localparam logic [CSR_ADDR_W-1:0] CSR_CUSTOM_MTIMECMP = 12'hBC1;
    localparam logic [CSR_ADDR_W-1:0] CSR_CUSTOM_LFSR     = 12'hBC2;

    // Bit positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIP_MTIP_BIT     = 7;

    // mcause values with the interrupt flag in the top bit
    localparam logic [XLEN-1:0] CAUSE_TIMER_INT    = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INST = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT   = 32'd3;
    localparam logic [XLEN-1:0] CAUSE_MISALIGNED   = 32'd4;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_CSR  = 32'd11;

    // Taps 31 21 1 0 of x^32 + x^22 + x^2 + x + 1
    localparam logic [XLEN-1:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [XLEN-1:0] LFSR_SEED = 32'd1;

    // Word view for software and field view for trap updates
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [XLEN-1:MSTATUS_MPIE_BIT+1]             rsvd_hi;
            logic                                         mpie;
            logic [MSTATUS_MPIE_BIT-1:MSTATUS_MIE_BIT+1] rsvd_mid;
            logic                                         mie;
            logic [MSTATUS_MIE_BIT-1:0]                   rsvd_lo;
        } fields;
    } mstatus_u;

    // New register value for write, set or clear
    function automatic logic [XLEN-1:0] csr_apply_op(
        input logic [XLEN-1:0] old_val,
        input logic [1:0]      op,
        input logic [XLEN-1:0] wdata
    );
        case (op)
            CSR_OP_WRITE: return wdata;
            CSR_OP_SET:   return old_val | wdata;
            CSR_OP_CLEAR: return old_val & ~wdata;
            default:      return old_val;
        endcase
    endfunction

endpackage

// File: common/csr_bus_if.sv
interface csr_bus_if;
    import csr_pkg::*;

    // Strobes act in the cycle they are high
    logic                  wren;
    logic                  rden;
    logic [1:0]            op;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;

    // Decoder side
    modport access (
        output wren, rden, op, addr, wdata
    );

    // Register block side
    modport target (
        input wren, rden, op, addr, wdata
    );

endinterface

// File: design/csr_access.sv
module csr_access (
    input  logic                          csr_wren,
    input  logic                          csr_rden,
    input  logic [1:0]                    csr_op,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  logic [csr_pkg::XLEN-1:0]      csr_imm,
    input  logic                          csr_imm_sel,
    input  logic [csr_pkg::XLEN-1:0]      rs1_data,
    csr_bus_if.access                     bus,
    input  logic [csr_pkg::XLEN-1:0]      counters_rdata,
    input  logic [csr_pkg::XLEN-1:0]      trap_rdata,
    output logic [csr_pkg::XLEN-1:0]      csr_rdata
);
    import csr_pkg::*;

    logic [XLEN-1:0] wr_src;
    logic [XLEN-1:0] merged_rdata;

    // ====================
    // Write side
    // ====================
    // Immediate form or register form
    assign wr_src = csr_imm_sel ? csr_imm : rs1_data;

    assign bus.wren  = csr_wren;
    assign bus.rden  = csr_rden;
    assign bus.op    = csr_op;
    assign bus.addr  = csr_addr;
    assign bus.wdata = wr_src;

    // ====================
    // Read side
    // ====================
    // Each block returns zero off its own addresses
    assign merged_rdata = counters_rdata | trap_rdata;

    // Nothing on the read port without a read strobe
    assign csr_rdata = csr_rden ? merged_rdata : '0;

endmodule

// File: csr_counters/csr_counters.sv
module csr_counters (
    input  logic                     clk,
    input  logic                     rst_n,
    csr_bus_if.target                bus,
    input  logic                     retired,
    output logic [csr_pkg::XLEN-1:0] rdata,
    output logic                     mtime_reached
);
    import csr_pkg::*;

    logic [2*XLEN-1:0] mcycle;
    logic [2*XLEN-1:0] minstret;
    logic [XLEN-1:0]   mtime;
    logic [XLEN-1:0]   mtimecmp;
    logic [XLEN-1:0]   lfsr;

    logic [2*XLEN-1:0] mcycle_nxt;
    logic [2*XLEN-1:0] minstret_nxt;
    logic [XLEN-1:0]   mtimecmp_nxt;
    logic [XLEN-1:0]   lfsr_nxt;
    logic [XLEN-1:0]   lfsr_shift;
    logic              lfsr_fb;
    logic              lfsr_rd;

    // ====================
    // Random number
    // ====================
    // Fibonacci form with feedback entering at the top
    assign lfsr_fb    = ^(lfsr & LFSR_TAPS);
    assign lfsr_shift = {lfsr_fb, lfsr[XLEN-1:1]};
    assign lfsr_rd    = bus.rden && (bus.addr == CSR_CUSTOM_LFSR);

    // Timer compare level for the trap block
    assign mtime_reached = (mtime >= mtimecmp);

    // ====================
    // Next state
    // ====================
    always_comb begin
        // Hardware updates
        mcycle_nxt   = mcycle + 64'd1;
        minstret_nxt = minstret + {63'd0, retired};
        mtimecmp_nxt = mtimecmp;
        lfsr_nxt     = lfsr;
        // Each read draws a new number
        if (lfsr_rd) begin
            lfsr_nxt = lfsr_shift;
        end
        // Software writes win over the counting above
        // Only the addressed half is replaced
        if (bus.wren) begin
            case (bus.addr)
                CSR_MCYCLE:
                    mcycle_nxt[XLEN-1:0] = csr_apply_op(mcycle[XLEN-1:0], bus.op, bus.wdata);
                CSR_MCYCLEH:
                    mcycle_nxt[2*XLEN-1:XLEN] =
                        csr_apply_op(mcycle[2*XLEN-1:XLEN], bus.op, bus.wdata);
                CSR_MINSTRET:
                    minstret_nxt[XLEN-1:0] =
                        csr_apply_op(minstret[XLEN-1:0], bus.op, bus.wdata);
                CSR_MINSTRETH:
                    minstret_nxt[2*XLEN-1:XLEN] =
                        csr_apply_op(minstret[2*XLEN-1:XLEN], bus.op, bus.wdata);
                CSR_CUSTOM_MTIMECMP:
                    mtimecmp_nxt = csr_apply_op(mtimecmp, bus.op, bus.wdata);
                CSR_CUSTOM_LFSR:
                    lfsr_nxt = csr_apply_op(lfsr, bus.op, bus.wdata);
                // Aliases and mtime are read only
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle   <= '0;
            minstret <= '0;
            mtime    <= '0;
            mtimecmp <= '0;
            // Never start from all zeros
            lfsr     <= LFSR_SEED;
        end else begin
            mcycle   <= mcycle_nxt;
            minstret <= minstret_nxt;
            mtime    <= mtime + 32'd1;
            mtimecmp <= mtimecmp_nxt;
            lfsr     <= lfsr_nxt;
        end
    end

    // ====================
    // Read data
    // ====================
    always_comb begin
        case (bus.addr)
            CSR_MCYCLE, CSR_CYCLE:         rdata = mcycle[XLEN-1:0];
            CSR_MCYCLEH, CSR_CYCLEH:       rdata = mcycle[2*XLEN-1:XLEN];
            CSR_MINSTRET, CSR_INSTRET:     rdata = minstret[XLEN-1:0];
            CSR_MINSTRETH, CSR_INSTRETH:   rdata = minstret[2*XLEN-1:XLEN];
            CSR_CUSTOM_MTIME:              rdata = mtime;
            CSR_CUSTOM_MTIMECMP:           rdata = mtimecmp;
            // Return the advanced value and never the stored seed
            CSR_CUSTOM_LFSR:               rdata = lfsr_shift;
            default:                       rdata = '0;
        endcase
    end

endmodule

// File: csr_trap/csr_trap_unit.sv
module csr_trap_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    csr_bus_if.target                bus,
    input  logic                     mtime_reached,
    input  logic                     timer_int_taken,
    input  logic                     illegal_inst,
    input  logic                     misaligned,
    input  logic                     illegal_csr,
    input  logic                     breakpoint,
    input  logic                     mret,
    input  logic [csr_pkg::XLEN-1:0] trap_pc,
    input  logic [csr_pkg::XLEN-1:0] trap_tval,
    output logic [csr_pkg::XLEN-1:0] rdata,
    output logic                     timer_int_enable,
    output logic                     trap_jump_en,
    output logic                     trap_return_en,
    output logic [csr_pkg::XLEN-1:0] trap_jump_addr,
    output logic [csr_pkg::XLEN-1:0] trap_return_addr
);
    import csr_pkg::*;

    mstatus_u        mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;

    mstatus_u        mstatus_nxt;
    logic [XLEN-1:0] mie_nxt;
    logic [XLEN-1:0] mip_nxt;
    logic [XLEN-1:0] mtvec_nxt;
    logic [XLEN-1:0] mscratch_nxt;
    logic [XLEN-1:0] mepc_nxt;
    logic [XLEN-1:0] mcause_nxt;
    logic [XLEN-1:0] mtval_nxt;

    logic            exc_any;
    logic            trap_any;
    logic [XLEN-1:0] trap_cause;

    // ====================
    // Trap decode
    // ====================
    assign exc_any  = illegal_inst | misaligned | illegal_csr | breakpoint;
    assign trap_any = exc_any | timer_int_taken;

    // Later sources override earlier ones
    always_comb begin
        trap_cause = CAUSE_TIMER_INT;
        if (illegal_inst) trap_cause = CAUSE_ILLEGAL_INST;
        if (misaligned)   trap_cause = CAUSE_MISALIGNED;
        if (illegal_csr)  trap_cause = CAUSE_ILLEGAL_CSR;
        if (breakpoint)   trap_cause = CAUSE_BREAKPOINT;
    end

    // Redirect to the core in the same cycle
    assign trap_jump_en     = trap_any;
    assign trap_jump_addr   = mtvec;
    assign trap_return_en   = mret;
    assign trap_return_addr = mepc;

    // Pending, globally enabled, locally enabled
    assign timer_int_enable = mip[MIP_MTIP_BIT] & mstatus.fields.mie & mie[MIE_MTIE_BIT];

    // ====================
    // Next state
    // ====================
    always_comb begin
        mstatus_nxt  = mstatus;
        mie_nxt      = mie;
        mip_nxt      = mip;
        mtvec_nxt    = mtvec;
        mscratch_nxt = mscratch;
        mepc_nxt     = mepc;
        mcause_nxt   = mcause;
        mtval_nxt    = mtval;
        // Timer pending follows the compare one cycle late
        mip_nxt[MIP_MTIP_BIT] = mtime_reached;
        // Trap entry
        if (trap_any) begin
            mcause_nxt = trap_cause;
            mepc_nxt   = trap_pc;
            // No tval for the timer interrupt
            if (exc_any) begin
                mtval_nxt = trap_tval;
            end
            // Block nesting until mret
            mstatus_nxt.fields.mpie = mstatus.fields.mie;
            mstatus_nxt.fields.mie  = 1'b0;
        end
        // Trap return
        if (mret) begin
            mstatus_nxt.fields.mie = mstatus.fields.mpie;
        end
        // Software writes last
        if (bus.wren) begin
            case (bus.addr)
                CSR_MSTATUS:  mstatus_nxt.word = csr_apply_op(mstatus.word, bus.op, bus.wdata);
                CSR_MIE:      mie_nxt      = csr_apply_op(mie, bus.op, bus.wdata);
                CSR_MIP:      mip_nxt      = csr_apply_op(mip, bus.op, bus.wdata);
                CSR_MTVEC:    mtvec_nxt    = csr_apply_op(mtvec, bus.op, bus.wdata);
                CSR_MSCRATCH: mscratch_nxt = csr_apply_op(mscratch, bus.op, bus.wdata);
                CSR_MEPC:     mepc_nxt     = csr_apply_op(mepc, bus.op, bus.wdata);
                CSR_MCAUSE:   mcause_nxt   = csr_apply_op(mcause, bus.op, bus.wdata);
                CSR_MTVAL:    mtval_nxt    = csr_apply_op(mtval, bus.op, bus.wdata);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus  <= '0;
            mie      <= '0;
            mip      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            mstatus  <= mstatus_nxt;
            mie      <= mie_nxt;
            mip      <= mip_nxt;
            mtvec    <= mtvec_nxt;
            mscratch <= mscratch_nxt;
            mepc     <= mepc_nxt;
            mcause   <= mcause_nxt;
            mtval    <= mtval_nxt;
        end
    end

    // ====================
    // Read data
    // ====================
    always_comb begin
        case (bus.addr)
            CSR_MSTATUS:  rdata = mstatus.word;
            CSR_MIE:      rdata = mie;
            CSR_MIP:      rdata = mip;
            CSR_MTVEC:    rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE:   rdata = mcause;
            CSR_MTVAL:    rdata = mtval;
            default:      rdata = '0;
        endcase
    end

endmodule

// File: design/csr_unit.sv
module csr_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    // Software access
    input  logic                           csr_wren,
    input  logic                           csr_rden,
    input  logic [1:0]                     csr_op,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  logic [csr_pkg::XLEN-1:0]       csr_imm,
    input  logic                           csr_imm_sel,
    input  logic [csr_pkg::XLEN-1:0]       rs1_data,
    // Retire strobe from the core
    input  logic                           retired,
    // Trap sources
    input  logic                           timer_int_taken,
    input  logic                           illegal_inst,
    input  logic                           misaligned,
    input  logic                           illegal_csr,
    input  logic                           breakpoint,
    input  logic                           mret,
    input  logic [csr_pkg::XLEN-1:0]       trap_pc,
    input  logic [csr_pkg::XLEN-1:0]       trap_tval,
    // Results to the core
    output logic [csr_pkg::XLEN-1:0]       csr_rdata,
    output logic                           timer_int_enable,
    output logic                           trap_jump_en,
    output logic [csr_pkg::XLEN-1:0]       trap_jump_addr,
    output logic                           trap_return_en,
    output logic [csr_pkg::XLEN-1:0]       trap_return_addr
);
    import csr_pkg::*;

    logic [XLEN-1:0] counters_rdata;
    logic [XLEN-1:0] trap_rdata;
    logic            mtime_reached;

    csr_bus_if bus ();

    // Decoder drives the shared bus
    csr_access i_csr_access (
        .csr_wren       (csr_wren),
        .csr_rden       (csr_rden),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_imm        (csr_imm),
        .csr_imm_sel    (csr_imm_sel),
        .rs1_data       (rs1_data),
        .bus            (bus),
        .counters_rdata (counters_rdata),
        .trap_rdata     (trap_rdata),
        .csr_rdata      (csr_rdata)
    );

    // Counters, timer, random number
    csr_counters i_csr_counters (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (bus),
        .retired       (retired),
        .rdata         (counters_rdata),
        .mtime_reached (mtime_reached)
    );

    // Trap CSRs and redirect
    csr_trap_unit i_csr_trap_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .bus              (bus),
        .mtime_reached    (mtime_reached),
        .timer_int_taken  (timer_int_taken),
        .illegal_inst     (illegal_inst),
        .misaligned       (misaligned),
        .illegal_csr      (illegal_csr),
        .breakpoint       (breakpoint),
        .mret             (mret),
        .trap_pc          (trap_pc),
        .trap_tval        (trap_tval),
        .rdata            (trap_rdata),
        .timer_int_enable (timer_int_enable),
        .trap_jump_en     (trap_jump_en),
        .trap_return_en   (trap_return_en),
        .trap_jump_addr   (trap_jump_addr),
        .trap_return_addr (trap_return_addr)
    );

endmodule

// File: bench/csr_unit_tb.sv
module csr_unit_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 10;
    // All tests take about 130 cycles and the limit leaves a wide margin
    localparam int MAX_CYCLES   = 2000;

    logic        clk;
    logic        rst_n;
    logic        csr_wren, csr_rden, csr_imm_sel, retired;
    logic [1:0]  csr_op;
    logic [11:0] csr_addr;
    logic [31:0] csr_imm, rs1_data, trap_pc, trap_tval;
    logic        timer_int_taken, illegal_inst, misaligned, illegal_csr, breakpoint, mret;
    logic [31:0] csr_rdata, trap_jump_addr, trap_return_addr;
    logic        timer_int_enable, trap_jump_en, trap_return_en;

    int          errors;
    int          passes;
    int          test_start_errors;
    int          cycle_count;
    logic [15:0] rand_state;
    // mtval written by the last exception
    logic [31:0] exp_tval;

    csr_unit i_csr_unit (.*);

    // ====================
    // Clock and timeout
    // ====================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // ====================
    // Models
    // ====================
    // Stimulus data from x^16+x^14+x^13+x^11+1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = rand_state[15] ^ rand_state[13] ^ rand_state[12] ^ rand_state[10];
            rand_state = {rand_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Random-number CSR with taps 31 21 1 0 and feedback into the top bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {fb, s[31:1]};
    endfunction

    // Code 0 keeps the old value
    function automatic logic [31:0] op_model(input logic [31:0] old_val, input logic [1:0] op,
                                             input logic [31:0] data);
        case (op)
            2'd1:    return data;
            2'd2:    return old_val | data;
            2'd3:    return old_val & ~data;
            default: return old_val;
        endcase
    endfunction

    // ====================
    // Driver tasks
    // ====================
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end else begin
            passes++;
        end
    endtask

    task automatic clear_strobes();
        csr_wren        = 1'b0;
        csr_rden        = 1'b0;
        csr_op          = 2'd0;
        retired         = 1'b0;
        timer_int_taken = 1'b0;
        illegal_inst    = 1'b0;
        misaligned      = 1'b0;
        illegal_csr     = 1'b0;
        breakpoint      = 1'b0;
        mret            = 1'b0;
    endtask

    // One op per cycle acting at the edge that ends the cycle
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        clear_strobes();
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [1:0] op,
                             input logic [31:0] data, input logic imm);
        next_cycle();
        csr_wren    = 1'b1;
        csr_op      = op;
        csr_addr    = addr;
        csr_imm_sel = imm;
        // Unselected source carries the inverse
        csr_imm     = imm ? data : ~data;
        rs1_data    = imm ? ~data : data;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        next_cycle();
        csr_rden = 1'b1;
        csr_addr = addr;
        #SAMPLE_DELAY;
        data = csr_rdata;
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ====================
    // Tests
    // ====================
    task automatic test_reset_reads();
        logic [31:0] rd;
        csr_read(CSR_MSTATUS, rd);
        check_value("mstatus", 32'd0, rd);
        csr_read(CSR_MEPC, rd);
        check_value("mepc", 32'd0, rd);
        csr_read(CSR_MCAUSE, rd);
        check_value("mcause", 32'd0, rd);
        // mvendorid is not mapped
        csr_read(12'hF11, rd);
        check_value("mvendorid", 32'd0, rd);
        // mcycle is already nonzero here
        next_cycle();
        csr_addr = CSR_MCYCLE;
        #SAMPLE_DELAY;
        check_value("csr_rdata with rden low", 32'd0, csr_rdata);
        check_value("timer_int_enable", 32'd0, {31'd0, timer_int_enable});
        check_value("trap_jump_en", 32'd0, {31'd0, trap_jump_en});
    endtask

    task automatic test_write_ops();
        logic [31:0] scratch_exp;
        logic [31:0] tvec_exp;
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] c0;
        logic [1:0]  op;
        scratch_exp = '0;
        tvec_exp    = '0;
        for (int i = 0; i < 8; i++) begin
            // Write, set and clear in turn from both sources
            op = 2'(i % 3 + 1);
            data = take_bits(32);
            csr_write(CSR_MSCRATCH, op, data, i[0]);
            scratch_exp = op_model(scratch_exp, op, data);
            csr_read(CSR_MSCRATCH, rd);
            check_value("mscratch", scratch_exp, rd);
            data = take_bits(32);
            csr_write(CSR_MTVEC, op, data, ~i[0]);
            tvec_exp = op_model(tvec_exp, op, data);
            csr_read(CSR_MTVEC, rd);
            check_value("mtvec", tvec_exp, rd);
        end
        // Read-only alias keeps counting over the two cycles between reads
        csr_read(CSR_CYCLE, c0);
        csr_write(CSR_CYCLE, CSR_OP_WRITE, take_bits(32), 1'b0);
        csr_read(CSR_CYCLE, rd);
        check_value("cycle after write", c0 + 32'd2, rd);
    endtask

    task automatic test_counters();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        int          n;
        n = 5 + int'(take_bits(3));
        csr_read(CSR_MCYCLE, a);
        repeat (n - 1) next_cycle();
        csr_read(CSR_MCYCLE, b);
        check_value("mcycle delta", n, b - a);
        // Top bit clear so the low word cannot carry
        v = take_bits(31);
        csr_write(CSR_MINSTRET, CSR_OP_WRITE, v, 1'b0);
        n = 1 + int'(take_bits(3));
        repeat (n) begin
            next_cycle();
            retired = 1'b1;
        end
        csr_read(CSR_MINSTRET, a);
        check_value("minstret", v + n, a);
        csr_read(CSR_INSTRET, b);
        check_value("instret alias", v + n, b);
        // One port means the alias read is one cycle ahead
        csr_read(CSR_CYCLE, a);
        csr_read(CSR_MCYCLE, b);
        check_value("mcycle vs cycle", a + 32'd1, b);
        csr_read(CSR_MCYCLEH, a);
        // At least one bit is set
        v = (take_bits(8) | 32'd1) << 8;
        csr_write(CSR_MCYCLEH, CSR_OP_SET, v, 1'b1);
        csr_read(CSR_CYCLEH, b);
        check_value("cycleh after set", a | v, b);
    endtask

    task automatic test_traps();
        logic [31:0] tvec;
        logic [31:0] pc;
        logic [31:0] rd;
        mstatus_u    ms;
        tvec = take_bits(32) & ~32'd3;
        csr_write(CSR_MTVEC, CSR_OP_WRITE, tvec, 1'b0);
        csr_write(CSR_MSTATUS, CSR_OP_SET, 32'd1 << MSTATUS_MIE_BIT, 1'b1);
        pc       = take_bits(32) & ~32'd3;
        exp_tval = take_bits(32);
        next_cycle();
        illegal_inst = 1'b1;
        trap_pc      = pc;
        trap_tval    = exp_tval;
        #SAMPLE_DELAY;
        check_value("trap_jump_en", 32'd1, {31'd0, trap_jump_en});
        check_value("trap_jump_addr", tvec, trap_jump_addr);
        csr_read(CSR_MEPC, rd);
        check_value("mepc", pc, rd);
        csr_read(CSR_MTVAL, rd);
        check_value("mtval", exp_tval, rd);
        csr_read(CSR_MCAUSE, rd);
        check_value("mcause illegal", 32'd2, rd);
        csr_read(CSR_MSTATUS, rd);
        ms.word = rd;
        check_value("mstatus.mie", 32'd0, {31'd0, ms.fields.mie});
        check_value("mstatus.mpie", 32'd1, {31'd0, ms.fields.mpie});
        // Breakpoint is last in priority order and wins
        pc = take_bits(32) & ~32'd3;
        next_cycle();
        illegal_inst = 1'b1;
        breakpoint   = 1'b1;
        trap_pc      = pc;
        csr_read(CSR_MCAUSE, rd);
        check_value("mcause breakpoint", 32'd3, rd);
        // MPIE is 0 after the nested trap and must be set for mret
        csr_write(CSR_MSTATUS, CSR_OP_WRITE, 32'd1 << MSTATUS_MPIE_BIT, 1'b0);
        next_cycle();
        mret = 1'b1;
        #SAMPLE_DELAY;
        check_value("trap_return_en", 32'd1, {31'd0, trap_return_en});
        check_value("trap_return_addr", pc, trap_return_addr);
        csr_read(CSR_MSTATUS, rd);
        ms.word = rd;
        check_value("mstatus.mie after mret", 32'd1, {31'd0, ms.fields.mie});
    endtask

    task automatic test_timer();
        logic [31:0] t;
        logic [31:0] rd;
        int          start;
        int          off;
        logic        seen;
        mstatus_u    ms;
        csr_read(CSR_CUSTOM_MTIME, t);
        start = cycle_count;
        // Compare first so the stale pending bit drains before MTIE
        csr_write(CSR_CUSTOM_MTIMECMP, CSR_OP_WRITE, t + 32'd20, 1'b0);
        csr_write(CSR_MIE, CSR_OP_SET, 32'd1 << MIE_MTIE_BIT, 1'b1);
        csr_write(CSR_MSTATUS, CSR_OP_SET, 32'd1 << MSTATUS_MIE_BIT, 1'b1);
        seen = 1'b0;
        off  = 0;
        // mtime reaches the compare at offset 20 and MTIP one cycle later
        while (!seen && off < 40) begin
            next_cycle();
            #SAMPLE_DELAY;
            off  = cycle_count - start;
            seen = timer_int_enable;
        end
        if (!seen) begin
            $display("timer_int_enable did not rise within 40 cycles of the mtime read");
            errors++;
        end else begin
            check_value("timer_int_enable rise offset", 32'd21, off);
        end
        next_cycle();
        timer_int_taken = 1'b1;
        trap_pc         = take_bits(32) & ~32'd3;
        trap_tval       = ~exp_tval;
        csr_read(CSR_MCAUSE, rd);
        check_value("mcause timer", 32'h8000_0007, rd);
        csr_read(CSR_MTVAL, rd);
        check_value("mtval kept on interrupt", exp_tval, rd);
        csr_read(CSR_MSTATUS, rd);
        ms.word = rd;
        check_value("mstatus.mie after interrupt", 32'd0, {31'd0, ms.fields.mie});
        check_value("timer_int_enable after entry", 32'd0, {31'd0, timer_int_enable});
    endtask

    task automatic test_random();
        logic [31:0] model;
        logic [31:0] rd;
        model = 32'd1;
        for (int i = 0; i < 8; i++) begin
            csr_read(CSR_CUSTOM_LFSR, rd);
            model = lfsr_step(model);
            check_value("lfsr from reset", model, rd);
        end
        // Odd seed is never all zeros
        model = take_bits(32) | 32'd1;
        csr_write(CSR_CUSTOM_LFSR, CSR_OP_WRITE, model, 1'b0);
        for (int i = 0; i < 8; i++) begin
            csr_read(CSR_CUSTOM_LFSR, rd);
            model = lfsr_step(model);
            check_value("lfsr from new seed", model, rd);
        end
    endtask

    // ====================
    // Sequence
    // ====================
    initial begin
        errors            = 0;
        passes            = 0;
        test_start_errors = 0;
        rand_state        = 16'd23;
        rst_n             = 1'b0;
        clear_strobes();
        csr_addr    = '0;
        csr_imm     = '0;
        csr_imm_sel = 1'b0;
        rs1_data    = '0;
        trap_pc     = '0;
        trap_tval   = '0;
        exp_tval    = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        test_reset_reads();
        report_test("reset_reads");
        test_write_ops();
        report_test("write_ops");
        test_counters();
        report_test("counters");
        test_traps();
        report_test("traps");
        test_timer();
        report_test("timer");
        test_random();
        report_test("random");
        $display("Checks passed %0d, failed %0d", passes, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
common/csr_pkg.sv
common/csr_bus_if.sv
design/csr_access.sv
csr_counters/csr_counters.sv
csr_trap/csr_trap_unit.sv
design/csr_unit.sv
bench/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module csr_unit_tb --Mdir obj_dir -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csr_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

# Result comes from the log
if grep -q "Simulation failed" "$LOG"; then
    echo "Testbench reported failure"
    exit 1
fi

exit 0
